//--- sim/dual_backend_testdata.txt
// columns: pc, instruction word, expected result; pc[11:8] is the test number
// word is {op, rd, rj, rk, imm13}; a pc of ffffffff ends the program
00000100 80800005 00000005
00000104 8100000C 0000000C
00000108 81801FFD FFFFFFFD
0000010C 92000123 09180000
00000110 828007FF 000007FF
00000114 83000064 00000064
00000118 13844000 00000011
0000011C 240C2000 FFFFFFF8
00000120 348CC000 00000064
00000124 4508A000 000007FF
00000128 5594C000 0000079B
00000200 8784000A 0000000F
00000204 183C4000 0000001B
00000208 28C1E000 0000000C
0000020C 59062000 00000009
00000300 9A000001 00080000
00000304 8A800035 00000035
00000308 4B52A000 00080035
0000030C 6BD84000 80035000
00000310 7C5C2000 04001A80
00000314 2CE2C000 03F81A4B
00000400 8F000007 00000007
00000404 AF88C000 000004B0
00000408 A3FBE000 000020D0
0000040C A40CA000 FFFFE803
00000410 249C2000 000020CB
00000414 15844000 00000011
00000418 A614C000 00031F9C
00000500 86800011 00000011
00000504 86800022 00000022
00000508 17340000 00000022
0000050C 88000003 00000003
00000510 A8084000 00000090
00000514 18BE0000 0000009F
00000518 80040009 0000000E
0000051C 1901A000 00000022
FFFFFFFF 00000000 00000000

//--- dual_backend.f
+incdir+hdl
hdl/dual_backend_pkg.sv
hdl/issue_decode.sv
hdl/reg_file.sv
hdl/exec_pipe.sv
hdl/commit_order.sv
hdl/dual_backend.sv
sim/dual_backend_tb.sv

//--- Bender.yml
package:
  name: dual_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dual_backend_pkg.sv
      - hdl/issue_decode.sv
      - hdl/reg_file.sv
      - hdl/exec_pipe.sv
      - hdl/commit_order.sv
      - hdl/dual_backend.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/dual_backend_tb.sv

//--- sim/dual_backend_tb.sv
`timescale 1ns/1ps

module dual_backend_tb;
	import dual_backend_pkg::*;

	localparam int MAX_INSTS = 128;
	localparam int NTESTS    = 6; // test 0 is the idle check after reset

	logic          clk;
	logic          arst_n_i;
	inst_t   [1:0] inst_i;
	logic    [1:0] inst_valid_i;
	logic    [1:0] issue_num_o;
	commit_t [1:0] commit_o;

	logic [31:0] tdata [3*MAX_INSTS]; // pc, word, result
	int          n_insts, head, issued_cnt, cur_test;
	int          due [2];             // commits due in 1 and 2 cycles
	int          exp_q [$];           // program indices in commit order
	int          remaining [NTESTS];
	int          test_errs [NTESTS];
	int          errors, checks, tests_done;
	logic        started, loaded, finished, first_issue;
	logic [31:0] lcg_state;
	string       test_name [NTESTS];

	dual_backend dut (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.issue_num_o  (issue_num_o),
		.commit_o     (commit_o)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic inst_t inst_at(int idx);
		inst_t i;
		i.pc = tdata[3*idx];
		i.word = tdata[3*idx+1];
		return i;
	endfunction

	function automatic int test_of(int idx);
		return int'(tdata[3*idx][11:8]) % NTESTS; // pc[11:8] numbers the test
	endfunction

	function automatic commit_t expected_commit(int idx);
		commit_t c;
		logic [31:0] w;
		w = tdata[3*idx+1];
		c.valid = 1'b1;
		c.pc = tdata[3*idx];
		c.rd = w[27:23];
		c.we = (w[31:28] != OP_NOP) && (w[27:23] != 5'd0); // r0 is never written
		c.result = tdata[3*idx+2];
		return c;
	endfunction

	function automatic string commit_str(commit_t c);
		return $sformatf("pc %h rd %0d we %0b result %h", c.pc, c.rd, c.we, c.result);
	endfunction

	// slot 1 waits on a same-cycle dependency or a second multiply
	function automatic logic [1:0] expected_issue(inst_t s0, inst_t s1, logic [1:0] v);
		logic [3:0] op0, op1;
		logic [4:0] rd0;
		logic       dep;
		op0 = s0.word[31:28];
		op1 = s1.word[31:28];
		rd0 = s0.word[27:23];
		dep = (op0 != OP_NOP) && (rd0 != 5'd0)
			&& ((!(op1 inside {OP_NOP, OP_LUI}) && (s1.word[22:18] == rd0))
			|| ((op1 inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_MUL})
			&& (s1.word[17:13] == rd0)));
		if (!v[0]) begin
			return 2'd0;
		end else if (!v[1] || dep || ((op0 == OP_MUL) && (op1 == OP_MUL))) begin
			return 2'd1;
		end
		return 2'd2;
	endfunction

	task automatic check_issue(input logic [1:0] got, input logic [1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs[cur_test]++;
			$display("MISMATCH at %0t: issue_num_o %0d, expected %0d, head pc %h",
				$time, got, exp, inst_i[0].pc);
		end
	endtask

	task automatic check_commit(input commit_t got, input commit_t exp, input int t);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errs[t]++;
			$display("MISMATCH at %0t: commit %s, expected %s",
				$time, commit_str(got), commit_str(exp));
		end
	endtask

	task automatic report_test(input int t);
		tests_done++;
		$display("test %0d %s: %s, %0d errors", t, test_name[t],
			(test_errs[t] == 0) ? "ok" : "FAILED", test_errs[t]);
	endtask

	initial begin
		clk = 1'b0;
		arst_n_i = 1'b0;
		inst_i = '0;
		inst_valid_i = 2'b00;
		{started, loaded, finished, first_issue} = 4'b0000;
		{head, issued_cnt, cur_test, errors, checks, tests_done} = '0;
		due = '{0, 0};
		remaining = '{default: 0};
		test_errs = '{default: 0};
		lcg_state = 32'd98599;
		test_name = '{"reset idle", "independent pairs", "same-cycle dependency",
			"forwarding paths", "multiply revert", "same-register writes"};
		$readmemh("sim/dual_backend_testdata.txt", tdata);
		n_insts = 0;
		while (n_insts < MAX_INSTS && !$isunknown(tdata[3*n_insts])
			&& tdata[3*n_insts] != 32'hffffffff) begin
			remaining[test_of(n_insts)]++;
			n_insts++;
		end
		if (n_insts == 0) begin
			errors++;
			$display("no instructions could be read from the test data file");
		end
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		arst_n_i <= 1'b1;
		started <= 1'b1;
		wait (finished);
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0 && tests_done == NTESTS) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// frontend model drops what was issued and offers the next two
	always @(posedge clk) begin
		if (started) begin
			head = head + issued_cnt;
			issued_cnt = 0;
			lcg_state = lcg_next(lcg_state);
			inst_i[0] <= (head < n_insts) ? inst_at(head) : '0;
			inst_valid_i[0] <= (head < n_insts);
			if (head + 1 < n_insts && lcg_state[15:14] != 2'b00) begin // slot 1 gap one in four
				inst_i[1] <= inst_at(head + 1);
				inst_valid_i[1] <= 1'b1;
			end else begin
				inst_i[1] <= '0;
				inst_valid_i[1] <= 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		int idx, t, offered;
		for (int s = 0; s < 2; s++) begin
			if (s < due[1]) begin
				idx = exp_q.pop_front();
				t = test_of(idx);
				if (commit_o[s].valid !== 1'b1) begin
					errors++;
					test_errs[t]++;
					$display("commit of pc %h missing in slot %0d at %0t",
						tdata[3*idx], s, $time);
				end else begin
					check_commit(commit_o[s], expected_commit(idx), t);
				end
				remaining[t]--;
				if (remaining[t] == 0) begin
					report_test(t);
				end
			end else if (commit_o[s].valid !== 1'b0) begin
				errors++;
				test_errs[cur_test]++;
				$display("commit slot %0d valid with nothing issued, at %0t", s, $time);
			end
		end
		due[1] = due[0];
		due[0] = 0;
		if (started && arst_n_i) begin
			if (inst_valid_i[0] && first_issue) begin
				cur_test = test_of(head);
			end
			check_issue(issue_num_o, expected_issue(inst_i[0], inst_i[1], inst_valid_i));
			offered = int'(inst_valid_i[0]) + int'(inst_valid_i[1]);
			issued_cnt = (int'(issue_num_o) > offered) ? offered : int'(issue_num_o);
			for (int k = 0; k < issued_cnt; k++) begin
				exp_q.push_back(head + k);
			end
			due[0] = issued_cnt;
			if (issued_cnt > 0 && !first_issue) begin
				first_issue = 1'b1;
				report_test(0);
				cur_test = test_of(head);
			end
		end
		if (started && head + issued_cnt >= n_insts && exp_q.size() == 0 && due[1] == 0) begin
			finished = 1'b1;
		end
	end

	// watchdog allows two cycles per instruction plus slack
	initial begin
		int limit_ns;
		wait (loaded);
		limit_ns = (n_insts + 20) * 2 * 100;
		#(limit_ns);
		$display("timeout: run did not finish within %0d ns", limit_ns);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- hdl/dual_backend.sv
`timescale 1ns/1ps
`include "dual_backend_cfg.svh"

module dual_backend (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  dual_backend_pkg::inst_t   [1:0] inst_i,       // slot 0 older
	input  logic                      [1:0] inst_valid_i,
	output logic                      [1:0] issue_num_o,  // 0, 1 or 2
	output dual_backend_pkg::commit_t [1:0] commit_o
);
	import dual_backend_pkg::*;

	ctrl_t   [1:0]                pipe_ctrl;
	ctrl_t   [1:0]                ex_ctrl;
	logic    [3:0][`DB_REG_W-1:0] rd_addr;
	logic    [3:0][`DB_XLEN-1:0]  rd_data;
	commit_t [1:0]                wb;
	logic    [1:0]                wb_older;
	logic    [1:0]                reg_we;
	logic    [1:0][`DB_REG_W-1:0] reg_waddr;
	logic    [1:0][`DB_XLEN-1:0]  reg_wdata;

	issue_decode issue_decode_module (
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.ex_ctrl_i    (ex_ctrl),
		.issue_num_o  (issue_num_o),
		.pipe_ctrl_o  (pipe_ctrl),
		.rd_addr_o    (rd_addr)
	);

	reg_file #(
		.NREGS (`DB_NREGS),
		.NREAD (4)
	) reg_file_module (
		.clk,
		.arst_n_i,
		.we_i    (reg_we),
		.waddr_i (reg_waddr),
		.wdata_i (reg_wdata),
		.raddr_i (rd_addr),
		.rdata_o (rd_data)
	);

	// main pipe, holds the multiplier
	exec_pipe #(
		.MAIN_PIPE (1'b1)
	) pipeline_0 (
		.clk,
		.arst_n_i,
		.ctrl_i     (pipe_ctrl[0]),
		.opa_i      (rd_data[0]),
		.opb_i      (rd_data[1]),
		.fwd0_i     (wb[0].result),
		.fwd1_i     (wb[1].result),
		.ex_ctrl_o  (ex_ctrl[0]),
		.wb_o       (wb[0]),
		.wb_older_o (wb_older[0])
	);

	exec_pipe #(
		.MAIN_PIPE (1'b0)
	) pipeline_1 (
		.clk,
		.arst_n_i,
		.ctrl_i     (pipe_ctrl[1]),
		.opa_i      (rd_data[2]),
		.opb_i      (rd_data[3]),
		.fwd0_i     (wb[0].result),
		.fwd1_i     (wb[1].result),
		.ex_ctrl_o  (ex_ctrl[1]),
		.wb_o       (wb[1]),
		.wb_older_o (wb_older[1])
	);

	commit_order commit_order_module (
		.wb_i       (wb),
		.wb_older_i (wb_older),
		.we_o       (reg_we),
		.waddr_o    (reg_waddr),
		.wdata_o    (reg_wdata),
		.commit_o   (commit_o)
	);

endmodule

//--- hdl/commit_order.sv
`timescale 1ns/1ps
`include "dual_backend_cfg.svh"

module commit_order (
	input  dual_backend_pkg::commit_t [1:0] wb_i,        // indexed by pipe
	input  logic                      [1:0] wb_older_i,
	output logic                      [1:0] we_o,
	output logic [1:0][`DB_REG_W-1:0]       waddr_o,
	output logic [1:0][`DB_XLEN-1:0]        wdata_o,
	output dual_backend_pkg::commit_t [1:0] commit_o     // program order, slot 0 older
);
	import dual_backend_pkg::*;

	logic swap;
	logic same_rd;

	// pipe 1 goes first after a revert, or when it is alone
	assign swap = wb_i[1].valid && (!wb_i[0].valid || (wb_older_i[1] && !wb_older_i[0]));

	assign commit_o[0] = swap ? wb_i[1] : wb_i[0];
	assign commit_o[1] = swap ? wb_i[0] : wb_i[1];

	assign same_rd = commit_o[0].valid && commit_o[0].we
		&& commit_o[1].valid && commit_o[1].we
		&& (commit_o[0].rd == commit_o[1].rd);

	// younger write wins, older one is dropped
	assign we_o[0] = commit_o[0].valid && commit_o[0].we && !same_rd;
	assign we_o[1] = commit_o[1].valid && commit_o[1].we;

	assign waddr_o[0] = commit_o[0].rd;
	assign waddr_o[1] = commit_o[1].rd;
	assign wdata_o[0] = commit_o[0].result;
	assign wdata_o[1] = commit_o[1].result;

endmodule

//--- hdl/exec_pipe.sv
`timescale 1ns/1ps
`include "dual_backend_cfg.svh"

module exec_pipe #(
	parameter bit MAIN_PIPE = 1'b1 // main pipe carries the multiplier
) (
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  dual_backend_pkg::ctrl_t   ctrl_i,
	input  logic [`DB_XLEN-1:0]       opa_i,
	input  logic [`DB_XLEN-1:0]       opb_i,
	input  logic [`DB_XLEN-1:0]       fwd0_i,     // WB result, pipe 0
	input  logic [`DB_XLEN-1:0]       fwd1_i,     // WB result, pipe 1
	output dual_backend_pkg::ctrl_t   ex_ctrl_o,
	output dual_backend_pkg::commit_t wb_o,
	output logic                      wb_older_o
);
	import dual_backend_pkg::*;

	localparam int SHAMT_W = $clog2(`DB_XLEN);

	ctrl_t                ex_ctrl_q;
	logic [`DB_XLEN-1:0]  ex_opa_q, ex_opb_q;
	logic [`DB_XLEN-1:0]  src_a, src_b;
	logic [`DB_XLEN-1:0]  mul_res, alu_res;
	logic                 wb_valid_q, wb_we_q, wb_older_q;
	logic [31:0]          wb_pc_q;
	logic [`DB_REG_W-1:0] wb_rd_q;
	logic [`DB_XLEN-1:0]  wb_result_q;

	function automatic logic [`DB_XLEN-1:0] pick(fwd_sel_e sel, logic [`DB_XLEN-1:0] reg_val,
		logic [`DB_XLEN-1:0] p0, logic [`DB_XLEN-1:0] p1);
		case (sel)
			FWD_PIPE0: return p0;
			FWD_PIPE1: return p1;
			default:   return reg_val;
		endcase
	endfunction

	// EX stage
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ex_ctrl_q <= '0;
		end else begin
			ex_ctrl_q <= ctrl_i;
		end
	end

	always_ff @(posedge clk) begin
		ex_opa_q <= opa_i;
		ex_opb_q <= opb_i;
	end

	assign ex_ctrl_o = ex_ctrl_q; // decode compares against this for forwarding

	assign src_a = pick(ex_ctrl_q.fwd_a, ex_opa_q, fwd0_i, fwd1_i);
	assign src_b = ex_ctrl_q.use_imm ? ex_ctrl_q.imm : pick(ex_ctrl_q.fwd_b, ex_opb_q, fwd0_i, fwd1_i);

	if (MAIN_PIPE) begin : g_mul
		assign mul_res = src_a * src_b; // low half of the product
	end else begin : g_no_mul
		assign mul_res = '0;
	end

	always_comb begin
		case (ex_ctrl_q.op)
			OP_ADD, OP_ADDI: alu_res = src_a + src_b;
			OP_SUB:          alu_res = src_a - src_b;
			OP_AND:          alu_res = src_a & src_b;
			OP_OR:           alu_res = src_a | src_b;
			OP_XOR:          alu_res = src_a ^ src_b;
			OP_SLL:          alu_res = src_a << src_b[SHAMT_W-1:0];
			OP_SRL:          alu_res = src_a >> src_b[SHAMT_W-1:0];
			OP_LUI:          alu_res = src_b; // imm already in the top bits
			OP_MUL:          alu_res = mul_res;
			default:         alu_res = '0;
		endcase
	end

	// WB stage
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid_q <= 1'b0;
			wb_we_q <= 1'b0;
			wb_older_q <= 1'b0;
		end else begin
			wb_valid_q <= ex_ctrl_q.valid;
			wb_we_q <= ctrl_writes(ex_ctrl_q);
			wb_older_q <= ex_ctrl_q.older;
		end
	end

	always_ff @(posedge clk) begin
		wb_pc_q <= ex_ctrl_q.pc;
		wb_rd_q <= ex_ctrl_q.rd;
		wb_result_q <= alu_res;
	end

	always_comb begin
		wb_o.valid = wb_valid_q;
		wb_o.pc = wb_pc_q;
		wb_o.rd = wb_rd_q;
		wb_o.we = wb_we_q;
		wb_o.result = wb_result_q;
	end

	assign wb_older_o = wb_older_q;

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`include "dual_backend_cfg.svh"

module reg_file #(
	parameter  int NREGS = `DB_NREGS,
	parameter  int NREAD = 4,
	localparam int AW    = $clog2(NREGS)
) (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  logic [1:0]                      we_i,     // port 1 is the younger write
	input  logic [1:0][AW-1:0]              waddr_i,
	input  logic [1:0][`DB_XLEN-1:0]        wdata_i,
	input  logic [NREAD-1:0][AW-1:0]        raddr_i,
	output logic [NREAD-1:0][`DB_XLEN-1:0]  rdata_o
);

	logic [`DB_XLEN-1:0] regs [NREGS];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int w = 0; w < 2; w++) begin
				if (we_i[w] && (waddr_i[w] != '0)) begin // r0 stays zero
					regs[waddr_i[w]] <= wdata_i[w];
				end
			end
		end
	end

	// write-to-read bypass so a same-cycle read sees the new value
	always_comb begin
		for (int r = 0; r < NREAD; r++) begin
			rdata_o[r] = regs[raddr_i[r]];
			for (int w = 0; w < 2; w++) begin
				if (we_i[w] && (waddr_i[w] == raddr_i[r])) begin
					rdata_o[r] = wdata_i[w];
				end
			end
			if (raddr_i[r] == '0) begin
				rdata_o[r] = '0;
			end
		end
	end

endmodule

//--- hdl/issue_decode.sv
`timescale 1ns/1ps
`include "dual_backend_cfg.svh"

module issue_decode (
	input  dual_backend_pkg::inst_t [1:0] inst_i,
	input  logic                    [1:0] inst_valid_i,
	input  dual_backend_pkg::ctrl_t [1:0] ex_ctrl_i,    // EX stage of pipe 0 and 1
	output logic                    [1:0] issue_num_o,
	output dual_backend_pkg::ctrl_t [1:0] pipe_ctrl_o,
	output logic [3:0][`DB_REG_W-1:0]     rd_addr_o     // {p1 rk, p1 rj, p0 rk, p0 rj}
);
	import dual_backend_pkg::*;

	localparam int IMM_W = 13;

	ctrl_t [1:0] dec;   // decoded slots, program order
	ctrl_t [1:0] slot;  // with issue, age and forwarding filled in
	logic        issue0, issue1;
	logic        raw_hazard, both_mul, revert;

	function automatic ctrl_t decode_word(inst_t inst, logic valid);
		ctrl_t c;
		logic  rd_j, rd_k;
		c = '0;
		c.valid = valid;
		c.pc = inst.pc;
		if (inst.word[31:28] > 4'(OP_MUL)) begin
			c.op = OP_NOP; // undefined opcodes do nothing
		end else begin
			c.op = opcode_e'(inst.word[31:28]);
		end
		rd_j = !(c.op inside {OP_NOP, OP_LUI});
		rd_k = c.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_MUL};
		c.rd = inst.word[27:23];
		c.rj = rd_j ? inst.word[22:18] : '0;
		c.rk = rd_k ? inst.word[17:13] : '0;
		c.use_imm = c.op inside {OP_ADDI, OP_LUI};
		if (c.op == OP_LUI) begin
			c.imm = {inst.word[IMM_W-1:0], {(`DB_XLEN-IMM_W){1'b0}}};
		end else begin
			c.imm = {{(`DB_XLEN-IMM_W){inst.word[IMM_W-1]}}, inst.word[IMM_W-1:0]};
		end
		return c;
	endfunction

	// match a source against both EX stages, younger producer wins
	function automatic fwd_sel_e fwd_for(logic [`DB_REG_W-1:0] src, ctrl_t [1:0] ex);
		logic hit0, hit1;
		hit0 = ctrl_writes(ex[0]) && (ex[0].rd == src);
		hit1 = ctrl_writes(ex[1]) && (ex[1].rd == src);
		if (hit0 && hit1) begin
			return ex[0].older ? FWD_PIPE1 : FWD_PIPE0;
		end else if (hit0) begin
			return FWD_PIPE0;
		end else if (hit1) begin
			return FWD_PIPE1;
		end
		return FWD_REG;
	endfunction

	assign dec[0] = decode_word(inst_i[0], inst_valid_i[0]);
	assign dec[1] = decode_word(inst_i[1], inst_valid_i[1]);

	// slot 1 may not read what slot 0 writes in the same cycle
	assign raw_hazard = ctrl_writes(dec[0]) && ((dec[1].rj == dec[0].rd) || (dec[1].rk == dec[0].rd));
	assign both_mul = (dec[0].op == OP_MUL) && (dec[1].op == OP_MUL); // one multiplier only

	assign issue0 = inst_valid_i[0];
	assign issue1 = issue0 && inst_valid_i[1] && !raw_hazard && !both_mul;
	assign revert = issue1 && (dec[0].op != OP_MUL) && (dec[1].op == OP_MUL);

	assign issue_num_o = {issue1, issue0 & ~issue1};

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			slot[s] = dec[s];
			slot[s].valid = (s == 0) ? issue0 : issue1;
			slot[s].older = (s == 0);
			slot[s].fwd_a = fwd_for(dec[s].rj, ex_ctrl_i);
			slot[s].fwd_b = fwd_for(dec[s].rk, ex_ctrl_i);
		end
	end

	// revert puts the multiply on the main pipe
	assign pipe_ctrl_o[0] = revert ? slot[1] : slot[0];
	assign pipe_ctrl_o[1] = revert ? slot[0] : slot[1];

	assign rd_addr_o[0] = pipe_ctrl_o[0].rj;
	assign rd_addr_o[1] = pipe_ctrl_o[0].rk;
	assign rd_addr_o[2] = pipe_ctrl_o[1].rj;
	assign rd_addr_o[3] = pipe_ctrl_o[1].rk;

endmodule

//--- hdl/dual_backend_pkg.sv
`include "dual_backend_cfg.svh"

package dual_backend_pkg;

	// top four bits of the instruction word
	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLL  = 4'h6,
		OP_SRL  = 4'h7,
		OP_ADDI = 4'h8,
		OP_LUI  = 4'h9,
		OP_MUL  = 4'ha
	} opcode_e;

	// one instruction as offered by the frontend
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] word;
	} inst_t;

	// operand source at EX
	typedef enum logic [1:0] {
		FWD_REG,   // register file value captured at issue
		FWD_PIPE0, // WB result of pipe 0
		FWD_PIPE1  // WB result of pipe 1
	} fwd_sel_e;

	typedef struct packed {
		logic                 valid;
		logic [31:0]          pc;     // carried along to the commit port
		opcode_e              op;
		logic [`DB_REG_W-1:0] rd;
		logic [`DB_REG_W-1:0] rj;     // zero when not read
		logic [`DB_REG_W-1:0] rk;     // zero when not read
		logic                 use_imm;
		logic [`DB_XLEN-1:0]  imm;    // already extended / shifted
		fwd_sel_e             fwd_a;
		fwd_sel_e             fwd_b;
		logic                 older;  // older of its issue pair
	} ctrl_t;

	typedef struct packed {
		logic                 valid;
		logic [31:0]          pc;
		logic [`DB_REG_W-1:0] rd;
		logic                 we;
		logic [`DB_XLEN-1:0]  result;
	} commit_t;

	// true when the instruction produces a register write
	function automatic logic ctrl_writes(ctrl_t c);
		return c.valid && (c.op != OP_NOP) && (c.rd != '0);
	endfunction

endpackage

//--- hdl/dual_backend_cfg.svh
`ifndef DUAL_BACKEND_CFG_SVH
`define DUAL_BACKEND_CFG_SVH

// datapath width, also the width of every register file entry
`define DB_XLEN 32

// architectural registers, r0 reads as zero
`define DB_NREGS 32

// register index width, matches the rd/rj/rk fields of the word
`define DB_REG_W 5

`endif
